// ==== build.f ====
common/fetch_pkg.sv
prefetch/prefetch_window.sv
hdl/insn_length_decoder.sv
hdl/fetch_sequencer.sv
hdl/fetch_unit.sv
sim/tb_clock.sv
sim/fetch_checker.sv
sim/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch unit testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_fetch_unit -f build.f \
    -o tb_fetch_unit > build.log 2>&1 \
    && ./obj_dir/tb_fetch_unit > sim.log 2>&1 \
    || echo "build or simulation did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "Done: no errors" sim.log 2>/dev/null && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// ==== sim/tb_fetch_unit.sv ====
/* fetch unit testbench */

module tb_fetch_unit;

    localparam logic [fetch_pkg::addr_w-1:0] reset_addr = 24'h000101;   // odd start
    localparam int n_insns    = 2000;
    localparam int clk_period = 40;
    localparam int timeout    = n_insns * 8 * clk_period * 2;   // generous per-insn budget

    logic                              clk;
    logic                              rst;
    logic                              cen;
    logic                              insn_ready;
    logic [fetch_pkg::word_w-1:0]      ram_dout;
    logic [fetch_pkg::addr_w-1:0]      ram_addr;
    logic                              insn_valid;
    fetch_pkg::opcode_t                insn_opcode;
    logic [fetch_pkg::field_w-1:0]     insn_field;
    logic [fetch_pkg::addr_w-1:0]      insn_operand;
    logic [fetch_pkg::addr_w-1:0]      insn_addr;
    logic [fetch_pkg::word_w-1:0]      mem [0:1023];    // program memory
    integer                            seed;
    int                                accepted;
    int                                errors;

    tb_clock #(.period(clk_period)) u_clk (.clk(clk));

    fetch_unit #(
        .reset_addr   (reset_addr)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .ram_dout     (ram_dout),
        .insn_ready   (insn_ready),
        .ram_addr     (ram_addr),
        .insn_valid   (insn_valid),
        .insn_opcode  (insn_opcode),
        .insn_field   (insn_field),
        .insn_operand (insn_operand),
        .insn_addr    (insn_addr)
    );

    // zero wait states, bit 0 ignored, aliases past 2 KB
    assign ram_dout = mem[ram_addr[10:1]];

    fetch_checker #(
        .reset_addr   (reset_addr)
    ) u_check (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .insn_ready   (insn_ready),
        .insn_valid   (insn_valid),
        .insn_opcode  (insn_opcode),
        .insn_field   (insn_field),
        .insn_operand (insn_operand),
        .insn_addr    (insn_addr),
        .ram_addr     (ram_addr),
        .mem          (mem),
        .accepted     (accepted),
        .errors       (errors)
    );

    initial begin : stimulus
        logic [31:0] r;
        seed       = 32'h95ad_5e4f;
        rst        = 1'b1;
        cen        = 1'b1;
        insn_ready = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            r      = $random(seed);
            mem[i] = r[15:0];
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // new cen and ready every falling edge
        while (accepted < n_insns) begin
            r          = $random(seed);
            cen        = (r[15:0] % 16'd100) >= 16'd20;      // ~80% enabled
            insn_ready = (r[31:16] % 16'd100) >= 16'd30;     // ~70% ready
            @(negedge clk);
        end
        $display("fetch checks: %0d instructions accepted, %0d errors", accepted, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout);
        $display("run stalled: %0d of %0d instructions accepted before the timeout",
                 accepted, n_insns);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== sim/fetch_checker.sv ====
/* fetch unit checker and model */

module fetch_checker #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_addr = '0
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic                              insn_ready,
    input  logic                              insn_valid,
    input  fetch_pkg::opcode_t                insn_opcode,
    input  logic [fetch_pkg::field_w-1:0]     insn_field,
    input  logic [fetch_pkg::addr_w-1:0]      insn_operand,
    input  logic [fetch_pkg::addr_w-1:0]      insn_addr,
    input  logic [fetch_pkg::addr_w-1:0]      ram_addr,
    input  logic [fetch_pkg::word_w-1:0]      mem [0:1023],    // array behind the memory model
    output int                                accepted,
    output int                                errors
);

    logic [fetch_pkg::addr_w-1:0] model_pc;       // where the program goes next
    logic                         last_jump;      // previous accepted insn redirected
    logic                         prev_valid;     // values seen at the last edge
    logic                         prev_cen;
    logic                         prev_ready;
    logic [fetch_pkg::addr_w-1:0] prev_opcode;    // widened for compare
    logic [fetch_pkg::addr_w-1:0] prev_field;
    logic [fetch_pkg::addr_w-1:0] prev_operand;
    logic [fetch_pkg::addr_w-1:0] prev_addr;

    // memory aliases every 2 KB
    function automatic logic [7:0] mem_byte(input logic [fetch_pkg::addr_w-1:0] a);
        logic [fetch_pkg::word_w-1:0] w;
        w = mem[a[10:1]];
        return a[0] ? w[15:8] : w[7:0];    // even address in the low lane
    endfunction

    task automatic compare_value(input string test, input string what,
                                 input logic [fetch_pkg::addr_w-1:0] exp,
                                 input logic [fetch_pkg::addr_w-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %h actual %h", test, what, exp, act);
        end
    endtask

    // DUT regs still hold their pre-edge values at the rising edge
    always @(posedge clk) begin : watch
        logic [7:0]                   b0;
        logic [7:0]                   b1;
        logic [7:0]                   b2;
        logic [7:0]                   b3;
        logic [2:0]                   exp_len;
        logic [fetch_pkg::addr_w-1:0] exp_operand;
        string                        test;
        if (rst) begin
            if (insn_valid !== 1'b0) begin
                errors++;
                $display("insn_valid is not low during reset");
            end
            if (ram_addr !== '0) begin
                errors++;
                $display("ram_addr is not zero during reset");
            end
            model_pc   = reset_addr;
            last_jump  = 1'b0;
            prev_valid = 1'b0;
            prev_cen   = 1'b1;
            prev_ready = 1'b0;
        end else begin
            // slot held over the last edge so nothing may move
            if (prev_valid && !(prev_cen && prev_ready)) begin
                test = prev_cen ? "backpressure" : "clock_enable";
                if (insn_valid !== 1'b1) begin
                    errors++;
                    $display("%s: insn_valid dropped before the instruction was accepted", test);
                end
                compare_value(test, "insn_opcode", prev_opcode, 24'(insn_opcode));
                compare_value(test, "insn_field", prev_field, 24'(insn_field));
                compare_value(test, "insn_operand", prev_operand, insn_operand);
                compare_value(test, "insn_addr", prev_addr, insn_addr);
            end else if (!prev_cen && insn_valid !== prev_valid) begin
                errors++;
                $display("clock_enable: insn_valid changed on a cycle with cen low");
            end
            // transfer on this edge
            if (cen && insn_valid && insn_ready) begin
                if (accepted == 0) begin
                    test = "reset";
                end else if (last_jump) begin
                    test = "jump";
                end else begin
                    test = "sequential";
                end
                b0 = mem_byte(model_pc);
                b1 = mem_byte(model_pc + 24'd1);
                b2 = mem_byte(model_pc + 24'd2);
                b3 = mem_byte(model_pc + 24'd3);
                exp_len = {1'b0, b0[7:6]} + 3'd1;     // 1..4 bytes by opcode
                case (b0[7:6])
                    2'd0:    exp_operand = '0;
                    2'd1:    exp_operand = {16'd0, b1};
                    2'd2:    exp_operand = {8'd0, b2, b1};
                    default: exp_operand = {b3, b2, b1};   // jump target
                endcase
                compare_value(test, "insn_addr", model_pc, insn_addr);
                compare_value(test, "insn_opcode", {22'd0, b0[7:6]}, 24'(insn_opcode));
                compare_value(test, "insn_field", {18'd0, b0[5:0]}, 24'(insn_field));
                compare_value(test, "insn_operand", exp_operand, insn_operand);
                last_jump = b0[7:6] == 2'd3;
                model_pc  = last_jump ? exp_operand : model_pc + {21'd0, exp_len};
                accepted++;
            end
            prev_valid   = insn_valid;
            prev_cen     = cen;
            prev_ready   = insn_ready;
            prev_opcode  = 24'(insn_opcode);
            prev_field   = 24'(insn_field);
            prev_operand = insn_operand;
            prev_addr    = insn_addr;
        end
    end

endmodule

// ==== sim/tb_clock.sv ====
/* testbench clock */

module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;    // 50% duty
    end

endmodule

// ==== hdl/fetch_unit.sv ====
/* instruction fetch top */

module fetch_unit #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_addr = '0
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic [fetch_pkg::word_w-1:0]       ram_dout,
    input  logic                               insn_ready,
    output logic [fetch_pkg::addr_w-1:0]       ram_addr,
    output logic                               insn_valid,
    output fetch_pkg::opcode_t                 insn_opcode,
    output logic [fetch_pkg::field_w-1:0]      insn_field,
    output logic [fetch_pkg::addr_w-1:0]       insn_operand,
    output logic [fetch_pkg::addr_w-1:0]       insn_addr
);

    logic [fetch_pkg::addr_w-1:0]    req_addr;      // program counter
    logic [fetch_pkg::window_w-1:0]  window_data;
    logic                            window_ok;
    logic                            take;
    logic [fetch_pkg::len_w-1:0]     take_len;
    logic [fetch_pkg::addr_w-1:0]    take_target;
    logic                            take_jump;

    fetch_sequencer #(
        .reset_addr  (reset_addr)
    ) u_seq (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .take        (take),
        .take_len    (take_len),
        .take_target (take_target),
        .take_jump   (take_jump),
        .req_addr    (req_addr)
    );

    // memory side
    prefetch_window u_window (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .req_addr    (req_addr),
        .ram_dout    (ram_dout),
        .ram_addr    (ram_addr),
        .window_data (window_data),
        .window_ok   (window_ok)
    );

    insn_length_decoder u_dec (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .window_data  (window_data),
        .window_ok    (window_ok),
        .req_addr     (req_addr),
        .insn_ready   (insn_ready),
        .take         (take),
        .take_len     (take_len),
        .take_target  (take_target),
        .take_jump    (take_jump),
        .insn_valid   (insn_valid),
        .insn_opcode  (insn_opcode),
        .insn_field   (insn_field),
        .insn_operand (insn_operand),
        .insn_addr    (insn_addr)
    );

endmodule

// ==== hdl/fetch_sequencer.sv ====
/* fetch program counter */

module fetch_sequencer #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_addr = '0
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic                              take,          // instruction leaves the window
    input  logic [fetch_pkg::len_w-1:0]       take_len,
    input  logic [fetch_pkg::addr_w-1:0]      take_target,
    input  logic                              take_jump,
    output logic [fetch_pkg::addr_w-1:0]      req_addr
);

    logic [fetch_pkg::addr_w-1:0] pc;
    logic [fetch_pkg::addr_w-1:0] seq_pc;      // fall-through address

    assign req_addr = pc;
    assign seq_pc   = pc + fetch_pkg::addr_w'(take_len);   // wraps at 24 bits

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= reset_addr;
        end else if (cen && take) begin
            if (take_jump) begin
                pc <= take_target;                   // redirect to the jump target
            end else begin
                pc <= seq_pc;
            end
        end
    end

    // decoder only offers real lengths
    len_in_range: assert property (
        @(posedge clk) disable iff (rst)
        take |-> (take_len >= 3'd1) && (take_len <= 3'd4)
    );

endmodule

// ==== hdl/insn_length_decoder.sv ====
/* instruction length decoder */

module insn_length_decoder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic [fetch_pkg::window_w-1:0]     window_data,
    input  logic                               window_ok,
    input  logic [fetch_pkg::addr_w-1:0]       req_addr,      // address of byte 0
    input  logic                               insn_ready,
    output logic                               take,
    output logic [fetch_pkg::len_w-1:0]        take_len,
    output logic [fetch_pkg::addr_w-1:0]       take_target,
    output logic                               take_jump,
    output logic                               insn_valid,
    output fetch_pkg::opcode_t                 insn_opcode,
    output logic [fetch_pkg::field_w-1:0]      insn_field,
    output logic [fetch_pkg::addr_w-1:0]       insn_operand,
    output logic [fetch_pkg::addr_w-1:0]       insn_addr
);

    fetch_pkg::opcode_t                dec_opcode;
    logic [fetch_pkg::addr_w-1:0]      dec_operand;
    logic                              slot_free;

    // opcode from the top bits of byte 0
    assign dec_opcode = fetch_pkg::opcode_t'(window_data[7:6]);

    // operand bytes follow little-endian
    always_comb begin
        dec_operand = '0;                                      // op_short has none
        case (dec_opcode)
            fetch_pkg::op_imm8:  dec_operand = {16'd0, window_data[15:8]};
            fetch_pkg::op_imm16: dec_operand = {8'd0, window_data[23:8]};
            fetch_pkg::op_jump:  dec_operand = window_data[31:8];
            default:             dec_operand = '0;
        endcase
    end

    // slot empty or emptied on this edge
    assign slot_free = !insn_valid || insn_ready;
    assign take      = window_ok && slot_free;

    // to the sequencer
    assign take_len    = fetch_pkg::insn_len(dec_opcode);
    assign take_jump   = dec_opcode == fetch_pkg::op_jump;
    assign take_target = window_data[fetch_pkg::window_w-1:8];   // jump target bytes 1..3

    // one-entry output slot, valid flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            insn_valid <= 1'b0;
        end else if (cen) begin
            if (take) begin
                insn_valid <= 1'b1;
            end else if (insn_ready) begin
                insn_valid <= 1'b0;                            // drained, nothing new
            end
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (cen && take) begin
            insn_opcode  <= dec_opcode;
            insn_field   <= window_data[5:0];
            insn_operand <= dec_operand;
            insn_addr    <= req_addr;
        end
    end

    // held instruction does not move until it is accepted
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        insn_valid && !(cen && insn_ready)
        |=> insn_valid && $stable({insn_opcode, insn_field, insn_operand, insn_addr})
    );

endmodule

// ==== prefetch/prefetch_window.sv ====
/* 4-byte prefetch window */

module prefetch_window (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cen,
    input  logic [fetch_pkg::addr_w-1:0]         req_addr,     // wanted window start
    input  logic [fetch_pkg::word_w-1:0]         ram_dout,     // word at ram_addr[23:1]
    output logic [fetch_pkg::addr_w-1:0]         ram_addr,
    output logic [fetch_pkg::window_w-1:0]       window_data,
    output logic                                 window_ok
);

    logic [fetch_pkg::addr_w-1:0] win_addr;     // address of byte 0
    logic [fetch_pkg::addr_w-1:0] addr_diff;    // forward distance to req_addr
    logic [3:0][7:0]              win_bytes;
    logic [3:0][7:0]              lane_byte;    // candidate byte from the bus
    logic [3:0]                   loaded;       // byte holds valid data
    logic [3:0]                   pending;      // byte still to be fetched
    logic [3:0]                   hit;          // pending byte present on the bus now
    logic [3:0]                   keep_mask;
    logic [1:0]                   adv;
    logic                         filling;
    logic                         near_move;
    logic                         start_shift;
    logic                         start_full;

    assign window_data = win_bytes;
    assign window_ok   = (&loaded) && (win_addr == req_addr);

    assign filling   = pending != 4'd0;
    assign addr_diff = req_addr - win_addr;      // wraps at 24 bits
    assign adv       = addr_diff[1:0];
    assign keep_mask = 4'b1111 >> adv;          // bytes that survive a short move

    // a move of 1..3 bytes over a full window keeps the overlap
    assign near_move   = (&loaded) && (addr_diff != '0)
                         && (addr_diff < fetch_pkg::addr_w'(4));
    assign start_shift = !filling && near_move;
    // anything else refetches, also right after reset
    assign start_full  = !filling && !near_move
                         && ((win_addr != req_addr) || !(&loaded));

    // which pending bytes sit in the word on the bus
    always_comb begin : lane_pick
        logic [fetch_pkg::addr_w-1:0] byte_addr;
        for (int i = 0; i < 4; i++) begin
            byte_addr    = win_addr + fetch_pkg::addr_w'(i);
            hit[i]       = pending[i]
                           && (byte_addr[fetch_pkg::addr_w-1:1] == ram_addr[fetch_pkg::addr_w-1:1]);
            // even address is the low lane
            lane_byte[i] = byte_addr[0] ? ram_dout[15:8] : ram_dout[7:0];
        end
    end

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_addr <= '0;
            ram_addr <= '0;
            loaded   <= '0;
            pending  <= '0;
        end else if (cen) begin
            if (filling) begin
                // zero wait states, one word per cycle
                ram_addr <= ram_addr + fetch_pkg::addr_w'(2);
                loaded   <= loaded | hit;
                pending  <= pending & ~hit;
            end else if (start_shift) begin
                win_addr <= req_addr;
                ram_addr <= win_addr + fetch_pkg::addr_w'(4);  // first byte past old window
                loaded   <= keep_mask;
                pending  <= ~keep_mask;
            end else if (start_full) begin
                win_addr <= req_addr;
                ram_addr <= req_addr;
                loaded   <= 4'b0000;
                pending  <= 4'b1111;
            end
        end
    end

    // byte storage
    always_ff @(posedge clk) begin
        if (cen) begin
            if (filling) begin
                for (int i = 0; i < 4; i++) begin
                    if (hit[i]) begin
                        win_bytes[i] <= lane_byte[i];
                    end
                end
            end else if (start_shift) begin
                win_bytes <= win_bytes >> {adv, 3'b000};   // drop the consumed bytes
            end
        end
    end

    // a usable window never waits on a fetch
    ok_not_pending: assert property (
        @(posedge clk) disable iff (rst)
        window_ok |-> pending == 4'd0
    );

    // a byte is either loaded or pending, never both
    flags_disjoint: assert property (
        @(posedge clk) disable iff (rst)
        (loaded & pending) == 4'd0
    );

endmodule

// ==== common/fetch_pkg.sv ====
/* fetch front end shared definitions */

package fetch_pkg;

    // bus and window widths
    parameter int addr_w   = 24;    // byte address
    parameter int word_w   = 16;    // program memory data bus
    parameter int window_w = 32;    // four bytes, byte 0 in bits 7:0
    parameter int len_w    = 3;     // instruction length 1..4
    parameter int field_w  = 6;     // low bits of the opcode byte

    // opcode lives in bits 7:6 of the first byte
    typedef enum logic [1:0] {
        op_short = 2'd0,    // opcode byte only
        op_imm8  = 2'd1,    // plus one immediate byte
        op_imm16 = 2'd2,    // plus two immediate bytes
        op_jump  = 2'd3     // plus 24-bit target
    } opcode_t;

    // bytes taken by one instruction
    function automatic logic [len_w-1:0] insn_len(opcode_t op);
        logic [len_w-1:0] len;
        case (op)
            op_short: len = 3'd1;
            op_imm8:  len = 3'd2;
            op_imm16: len = 3'd3;
            op_jump:  len = 3'd4;
            default:  len = 3'd1;
        endcase
        return len;
    endfunction

endpackage
